// File: design/pkg_tpu.sv
//////////////////////////////
// Shared types for the execution stage
// Command, token and write-back structs,
// opcode encodings and queue sizes
//////////////////////////////

package pkg_tpu;

	//////////////////////////////
	// Basic words
	//////////////////////////////

	typedef logic [31:0] data_t;       // Operand and result word
	typedef logic [5:0]  issue_no_t;   // Issue number, wraps at 64
	typedef logic [4:0]  dst_t;        // Destination register index

	typedef logic [1:0]  op_type_t;
	typedef logic [1:0]  op_class_t;

	// Operation field of a command
	typedef struct packed {
		op_type_t  op_type;    // Selects the unit
		op_class_t op_class;   // Operation within the unit
	} op_t;

	//////////////////////////////
	// Opcode encodings
	//////////////////////////////

	localparam op_type_t OP_ARITH = 2'd0;   // Multiply-add unit
	localparam op_type_t OP_SHIFT = 2'd2;   // Shift unit
	// op_type 1 and 3 are not executed here

	// Arithmetic classes
	localparam op_class_t CLS_ADD  = 2'd0;
	localparam op_class_t CLS_SUB  = 2'd1;
	localparam op_class_t CLS_MUL  = 2'd2;
	localparam op_class_t CLS_MADD = 2'd3;   // src1 * src2 + src3

	// Shift classes, amount from src2[4:0]
	localparam op_class_t CLS_SHL = 2'd0;
	localparam op_class_t CLS_SHR = 2'd1;
	localparam op_class_t CLS_SRA = 2'd2;
	localparam op_class_t CLS_ROL = 2'd3;

	//////////////////////////////
	// Command and write-back
	//////////////////////////////

	// 15 bits, travels through a unit as its token
	typedef struct packed {
		op_t       op;
		issue_no_t issue_no;   // Tag, used for oldest-first selection
		dst_t      dst;
	} cmd_t;

	// 47 bits, one result handed back to the lane
	typedef struct packed {
		cmd_t  token;
		data_t data;
	} wb_t;

	// Sizes
	localparam int MA_DEPTH  = 4;   // Multiply-add latency in cycles
	localparam int WBQ_DEPTH = 8;   // Entries per write-back queue, power of two
	localparam int WBQ_AW    = $clog2(WBQ_DEPTH);

endpackage

// File: design/ma_unit.sv
`timescale 1ns/1ps
//////////////////////////////
// Multiply-add unit
// Four-stage pipeline for add, sub, mul and madd
//////////////////////////////

module ma_unit #(
	parameter type TYPE = pkg_tpu::cmd_t
) (
	input  logic           clock,
	input  logic           rst,
	input  logic           en,
	input  pkg_tpu::data_t a,
	input  pkg_tpu::data_t b,
	input  pkg_tpu::data_t c,
	input  logic [1:0]     cls,
	input  TYPE            token,
	output logic           valid,
	output pkg_tpu::data_t data,
	output TYPE            token_out
);
	import pkg_tpu::*;

	// Registered operands of stage 1
	typedef struct packed {
		data_t     a;
		data_t     b;
		data_t     c;
		op_class_t cls;
	} ma_ops_t;

	logic    v1, v2, v3;
	ma_ops_t s1;
	TYPE     tok1, tok2, tok3;

	// Stage 2, partial products and addend
	data_t       pl2;         // a * b[15:0], low word
	logic [15:0] ph2;         // a[15:0] * b[31:16], low half
	data_t       a2;
	data_t       add2;
	logic        byp2;
	logic        sub2;

	// Stage 3, operands of the final adder
	data_t x3;
	data_t y3;
	logic  sub3;

	//////////////////////////////
	// Valid chain
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (rst) begin
			v1    <= 1'b0;
			v2    <= 1'b0;
			v3    <= 1'b0;
			valid <= 1'b0;
		end else begin
			v1    <= en;
			v2    <= v1;
			v3    <= v2;
			valid <= v3;
		end
	end

	//////////////////////////////
	// Datapath
	//////////////////////////////

	always_ff @(posedge clock) begin
		// Stage 1
		s1   <= '{a: a, b: b, c: c, cls: cls};
		tok1 <= token;

		// Stage 2, split multiply
		pl2  <= s1.a * {16'h0000, s1.b[15:0]};
		ph2  <= s1.a[15:0] * s1.b[31:16];
		a2   <= s1.a;
		byp2 <= (s1.cls == CLS_ADD) || (s1.cls == CLS_SUB);   // No product needed
		sub2 <= (s1.cls == CLS_SUB);
		case (s1.cls)
			CLS_MUL:  add2 <= '0;
			CLS_MADD: add2 <= s1.c;
			default:  add2 <= s1.b;
		endcase
		tok2 <= tok1;

		// Stage 3, combine partials or bypass
		x3   <= byp2 ? a2 : pl2 + {ph2, 16'h0000};
		y3   <= add2;
		sub3 <= sub2;
		tok3 <= tok2;

		// Stage 4
		data      <= sub3 ? x3 - y3 : x3 + y3;
		token_out <= tok3;
	end

	// Fixed latency, nothing inside the pipe may stall
	a_latency: assert property (@(posedge clock) disable iff (rst)
		$past(!rst, MA_DEPTH) |-> (valid == $past(en, MA_DEPTH)));

endmodule

// File: design/srl_unit.sv
`timescale 1ns/1ps
//////////////////////////////
// Shift unit
// One-stage barrel shift and rotate
//////////////////////////////

module srl_unit #(
	parameter type TYPE = pkg_tpu::cmd_t
) (
	input  logic           clock,
	input  logic           rst,
	input  logic           en,
	input  pkg_tpu::data_t a,
	input  pkg_tpu::data_t b,
	input  logic [1:0]     cls,
	input  TYPE            token,
	output logic           valid,
	output pkg_tpu::data_t data,
	output TYPE            token_out
);
	import pkg_tpu::*;

	logic [4:0] sh;
	logic       right;     // SHR and SRA run on the reversed word
	logic       rotate;
	logic       fill_one;  // Sign fill for SRA
	data_t      x;
	data_t      fill;
	data_t      res;

	function automatic data_t bit_rev(input data_t v);
		data_t r;
		for (int k = 0; k < 32; k++) begin
			r[k] = v[31 - k];
		end
		return r;
	endfunction

	assign sh       = b[4:0];
	assign right    = (cls == CLS_SHR) || (cls == CLS_SRA);
	assign rotate   = (cls == CLS_ROL);
	assign fill_one = (cls == CLS_SRA) && a[31];

	//////////////////////////////
	// Left barrel, five levels
	//////////////////////////////

	always_comb begin
		x    = right ? bit_rev(a) : a;
		fill = '0;
		for (int i = 0; i < 5; i++) begin
			if (sh[i]) begin
				if (rotate)
					fill = x >> (32 - (1 << i));   // Bits wrapping around
				else if (fill_one)
					fill = ~(32'hffff_ffff << (1 << i));
				else
					fill = '0;
				x = (x << (1 << i)) | fill;
			end
		end
		res = right ? bit_rev(x) : x;
	end

	always_ff @(posedge clock) begin
		if (rst)
			valid <= 1'b0;
		else
			valid <= en;
	end

	// Result and token, no reset
	always_ff @(posedge clock) begin
		data      <= res;
		token_out <= token;
	end

endmodule

// File: design/wb_arbiter.sv
`timescale 1ns/1ps
//////////////////////////////
// Write-back arbiter
// Per-unit result queues, oldest head first
//////////////////////////////

module wb_arbiter #(
	parameter type TYPE = pkg_tpu::wb_t
) (
	input  logic               clock,
	input  logic               rst,
	input  pkg_tpu::issue_no_t issue_no,
	input  logic               ma_valid,
	input  logic               srl_valid,
	input  TYPE                ma_res,
	input  TYPE                srl_res,
	output logic               done,
	output TYPE                wb
);
	import pkg_tpu::*;

	// Index 0 is the multiply-add queue, 1 the shift queue
	logic [1:0] push;
	logic [1:0] pop;
	logic [1:0] empty;
	logic [1:0] full;
	TYPE        in_res [2];
	TYPE        head   [2];
	issue_no_t  age    [2];   // Cycles of issue since the head was tagged
	logic       pick_srl;

	assign push      = {srl_valid, ma_valid};
	assign in_res[0] = ma_res;
	assign in_res[1] = srl_res;

	//////////////////////////////
	// Result queues
	//////////////////////////////

	for (genvar q = 0; q < 2; q++) begin : g_queue
		TYPE               mem [WBQ_DEPTH];
		logic [WBQ_AW-1:0] wr_ptr;
		logic [WBQ_AW-1:0] rd_ptr;
		logic [WBQ_AW:0]   count;

		assign empty[q] = (count == '0);
		assign full[q]  = (count == (WBQ_AW + 1)'(WBQ_DEPTH));
		assign head[q]  = mem[rd_ptr];
		assign age[q]   = issue_no - head[q].token.issue_no;

		always_ff @(posedge clock) begin
			if (push[q])
				mem[wr_ptr] <= in_res[q];
		end

		// Pointers wrap on their own, depth is a power of two
		always_ff @(posedge clock) begin
			if (rst) begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count  <= '0;
			end else begin
				if (push[q])
					wr_ptr <= wr_ptr + 1'b1;
				if (pop[q])
					rd_ptr <= rd_ptr + 1'b1;
				count <= count + (WBQ_AW + 1)'(push[q]) - (WBQ_AW + 1)'(pop[q]);
			end
		end

		a_no_overflow: assert property (@(posedge clock) disable iff (rst)
			push[q] |-> !full[q]);
	end

	//////////////////////////////
	// Oldest-first selection
	//////////////////////////////

	assign pick_srl = !empty[1] && (empty[0] || (age[1] > age[0]));
	assign pop[0]   = !empty[0] && !pick_srl;
	assign pop[1]   = pick_srl;

	always_ff @(posedge clock) begin
		if (rst)
			done <= 1'b0;
		else
			done <= |pop;
	end

	always_ff @(posedge clock) begin
		wb <= pick_srl ? head[1] : head[0];   // Only meaningful with done
	end

	a_done_src: assert property (@(posedge clock) disable iff (rst)
		done |-> $past(!(&empty)));

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
//////////////////////////////
// Execution stage top level
// Decode, two units, write-back arbiter
//////////////////////////////

module alu (
	input  logic               clock,
	input  logic               rst,
	input  pkg_tpu::issue_no_t issue_no,   // Current issue counter
	input  logic               req,
	input  logic               stall,      // Blocks new commands only
	input  pkg_tpu::cmd_t      command,
	input  pkg_tpu::data_t     src1,
	input  pkg_tpu::data_t     src2,
	input  pkg_tpu::data_t     src3,
	output logic               done,
	output pkg_tpu::wb_t       wb
);
	import pkg_tpu::*;

	logic  accept;
	logic  en_ma, en_srl;

	logic  ma_valid, srl_valid;
	data_t ma_data, srl_data;
	cmd_t  ma_tok, srl_tok;
	wb_t   ma_res, srl_res;

	// Unit steering, other op_type values are dropped
	assign accept = req & ~stall;
	assign en_ma  = accept & (command.op.op_type == OP_ARITH);
	assign en_srl = accept & (command.op.op_type == OP_SHIFT);

	ma_unit #(.TYPE(cmd_t)) u_ma (
		.clock     (clock),
		.rst       (rst),
		.en        (en_ma),
		.a         (src1),
		.b         (src2),
		.c         (src3),
		.cls       (command.op.op_class),
		.token     (command),
		.valid     (ma_valid),
		.data      (ma_data),
		.token_out (ma_tok)
	);

	srl_unit #(.TYPE(cmd_t)) u_srl (
		.clock     (clock),
		.rst       (rst),
		.en        (en_srl),
		.a         (src1),
		.b         (src2),
		.cls       (command.op.op_class),
		.token     (command),
		.valid     (srl_valid),
		.data      (srl_data),
		.token_out (srl_tok)
	);

	assign ma_res  = '{token: ma_tok, data: ma_data};
	assign srl_res = '{token: srl_tok, data: srl_data};

	wb_arbiter #(.TYPE(wb_t)) u_arb (
		.clock     (clock),
		.rst       (rst),
		.issue_no  (issue_no),
		.ma_valid  (ma_valid),
		.srl_valid (srl_valid),
		.ma_res    (ma_res),
		.srl_res   (srl_res),
		.done      (done),
		.wb        (wb)
	);

endmodule

// File: tests/alu_checker.sv
`timescale 1ns/1ps
//////////////////////////////
// Scoreboard for the execution stage
// Reference model, tag table, per-unit order
//////////////////////////////

module alu_checker (
	input  logic           clock,
	input  logic           rst,
	input  logic           req,
	input  logic           stall,
	input  pkg_tpu::cmd_t  command,
	input  pkg_tpu::data_t src1,
	input  pkg_tpu::data_t src2,
	input  pkg_tpu::data_t src3,
	input  logic           done,
	input  pkg_tpu::wb_t   wb,
	output int             errors,
	output int             outstanding,
	output int             checked
);
	import pkg_tpu::*;

	// One entry per tag
	bit        busy     [64];
	bit        is_shift [64];
	cmd_t      exp_cmd  [64];
	data_t     exp_data [64];
	issue_no_t ma_order  [$];   // Acceptance order per unit
	issue_no_t srl_order [$];
	bit        rst_d;

	function automatic data_t model_result(input op_t op, input data_t s1, s2, s3);
		logic [63:0] prod;
		logic [63:0] twice;
		logic [4:0]  amt;
		prod  = 64'(s1) * 64'(s2);
		amt   = s2[4:0];
		twice = {s1, s1} << amt;   // Upper half is the rotate
		if (op.op_type == OP_ARITH) begin
			case (op.op_class)
				CLS_ADD: return s1 + s2;
				CLS_SUB: return s1 - s2;
				CLS_MUL: return prod[31:0];
				default: return prod[31:0] + s3;
			endcase
		end
		case (op.op_class)
			CLS_SHL: return s1 << amt;
			CLS_SHR: return s1 >> amt;
			CLS_SRA: return $signed(s1) >>> amt;
			default: return twice[63:32];
		endcase
	endfunction

	task automatic record_command();
		issue_no_t tag;
		tag = command.issue_no;
		if (busy[tag]) begin
			errors++;
			$display("tag %0d issued again while still in flight", tag);
		end
		busy[tag]     = 1'b1;
		is_shift[tag] = (command.op.op_type == OP_SHIFT);
		exp_cmd[tag]  = command;
		exp_data[tag] = model_result(command.op, src1, src2, src3);
		if (is_shift[tag])
			srl_order.push_back(tag);
		else
			ma_order.push_back(tag);
		outstanding++;
	endtask

	task automatic retire_result();
		issue_no_t tag;
		issue_no_t first;
		tag = wb.token.issue_no;
		if ($isunknown(tag) || !busy[tag]) begin
			errors++;
			$display("done with tag %h, which has no command in flight", tag);
			return;
		end
		first = is_shift[tag] ? srl_order.pop_front() : ma_order.pop_front();
		if (first != tag) begin
			errors++;
			$display("mismatch wb.token.issue_no order: got %h expected %h", tag, first);
		end
		if (wb.token !== exp_cmd[tag]) begin
			errors++;
			$display("mismatch wb.token: got %h expected %h", wb.token, exp_cmd[tag]);
		end
		if (wb.data !== exp_data[tag]) begin
			errors++;
			$display("mismatch wb.data tag %h: got %h expected %h", tag, wb.data, exp_data[tag]);
		end
		busy[tag] = 1'b0;
		outstanding--;
		checked++;
	endtask

	always @(posedge clock) begin
		if (rst_d) begin
			if (done !== 1'b0) begin
				errors++;
				$display("done was not low during or right after reset");
			end
		end else if (!rst) begin
			if ($isunknown(done)) begin
				errors++;
				$display("done is unknown outside reset");
			end else if (done) begin
				retire_result();
			end
		end
		if (!rst && req === 1'b1 && stall === 1'b0 &&
			(command.op.op_type == OP_ARITH || command.op.op_type == OP_SHIFT))
			record_command();
		rst_d = rst;
	end

endmodule

// File: tests/tb_alu.sv
`timescale 1ns/1ps
//////////////////////////////
// Testbench for the execution stage
// Clock, reset, random commands from an LCG,
// drain, timeout and closing report
//////////////////////////////

module tb_alu;
	import pkg_tpu::*;

	localparam int RESET_CYCLES = 16;
	localparam int STIM_CYCLES  = 400;
	localparam int TIMEOUT      = STIM_CYCLES + RESET_CYCLES + STIM_CYCLES * 5 + 100;

	logic        clock = 1'b0;
	logic        rst;
	issue_no_t   issue_no;
	logic        req;
	logic        stall;
	cmd_t        command;
	data_t       src1;
	data_t       src2;
	data_t       src3;
	logic        done;
	wb_t         wb;

	int          errors;        // From the checker
	int          outstanding;
	int          checked;
	int          accepted;
	int          cycles;
	logic [31:0] lcg_state;
	issue_no_t   issue_cnt;     // Tag of the command on the bus

	always #50 clock = ~clock;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 15);   // Upper bits folded into the weak low bits
	endfunction

	// Mostly executable types, a few dropped ones
	function automatic op_type_t pick_op_type(input logic [31:0] r);
		if (r[31:28] < 4'd6)
			return OP_ARITH;
		if (r[31:28] < 4'd13)
			return OP_SHIFT;
		return r[27] ? 2'd1 : 2'd3;
	endfunction

	// Command currently on the bus is taken at this edge
	function automatic logic was_accepted();
		return req && !stall &&
			(command.op.op_type == OP_ARITH || command.op.op_type == OP_SHIFT);
	endfunction

	task automatic drive_random();
		logic [31:0] r;
		cmd_t        c;
		r             = lcg_next();
		c.op.op_type  = pick_op_type(r);
		c.op.op_class = r[25:24];
		c.issue_no    = issue_cnt;
		c.dst         = r[20:16];
		req      <= (r[15:14] != 2'b00);   // Three cycles in four
		stall    <= (r[13:11] == 3'b000);
		command  <= c;
		issue_no <= issue_cnt;
		src1     <= lcg_next();
		src2     <= lcg_next();
		src3     <= lcg_next();
	endtask

	alu uut (
		.clock    (clock),
		.rst      (rst),
		.issue_no (issue_no),
		.req      (req),
		.stall    (stall),
		.command  (command),
		.src1     (src1),
		.src2     (src2),
		.src3     (src3),
		.done     (done),
		.wb       (wb)
	);

	alu_checker u_check (
		.clock       (clock),
		.rst         (rst),
		.req         (req),
		.stall       (stall),
		.command     (command),
		.src1        (src1),
		.src2        (src2),
		.src3        (src3),
		.done        (done),
		.wb          (wb),
		.errors      (errors),
		.outstanding (outstanding),
		.checked     (checked)
	);

	//////////////////////////////
	// Stimulus and report
	//////////////////////////////

	initial begin
		lcg_state = 32'hd662b5eb;
		issue_cnt = '0;
		accepted  = 0;
		rst      <= 1'b1;
		req      <= 1'b0;
		stall    <= 1'b0;
		command  <= '0;
		issue_no <= '0;
		src1     <= '0;
		src2     <= '0;
		src3     <= '0;
		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		for (int n = 0; n <= STIM_CYCLES; n++) begin
			@(posedge clock);
			if (was_accepted()) begin
				accepted++;
				issue_cnt = issue_cnt + 1'b1;
			end
			if (n < STIM_CYCLES)
				drive_random();
		end
		req      <= 1'b0;   // Bus goes idle after the last counted edge
		issue_no <= issue_cnt;

		while (outstanding != 0) @(negedge clock);
		repeat (10) @(negedge clock);   // Room for stray results
		$display("Closing report: %0d accepted, %0d checked, %0d errors",
			accepted, checked, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d results still outstanding",
			cycles, outstanding);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: vlog.f
design/pkg_tpu.sv
design/ma_unit.sv
design/srl_unit.sv
design/wb_arbiter.sv
design/alu.sv
tests/alu_checker.sv
tests/tb_alu.sv

// File: Makefile
TOP := tb_alu
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module alu -f vlog.f

clean:
	rm -rf obj_dir $(LOG)
